//--- cart_mem_bridge.f
cart_mem_pkg.sv
loader_apb_regs.sv
mem_req_arbiter.sv
byte_lane_ram.sv
read_data_steer.sv
cart_mem_bridge.sv
cart_mem_bridge_assertions.sv
cart_mem_bridge_tb.sv

//--- Bender.yml
package:
  name: cart_mem_bridge

sources:
  - cart_mem_pkg.sv
  - loader_apb_regs.sv
  - mem_req_arbiter.sv
  - byte_lane_ram.sv
  - read_data_steer.sv
  - cart_mem_bridge.sv
  - target: test
    files:
      - cart_mem_bridge_assertions.sv
      - cart_mem_bridge_tb.sv

//--- cart_mem_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cart_mem_bridge_tb;
    import cart_mem_pkg::*;

    localparam int ADDR_W     = 14;
    localparam int CLK_PERIOD = 40;
    localparam int MEM_BYTES  = 2 ** ADDR_W;
    localparam logic [22:0] WRAM_TOP = 23'h7e0000;     // upper six bits all ones
    // rough cycles per test in run order
    localparam int TEST_CYCLES = 30 + 256 * 6 + 40 + 200 * 6 + 200 * 6 + 100;
    localparam int MAX_CYCLES  = TEST_CYCLES * 3 / 2;

    logic        wclk = 1'b0;
    logic        resetn;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    rom_req_t    rom_req;
    wram_req_t   wram_req;
    logic        sysclkf_ce;
    logic        sysclkr_ce;
    logic        snes_enable;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;

    logic [31:0] lfsr_state = 32'h298e;
    logic [7:0]  model_mem [MEM_BYTES];     // byte image of the on-chip ram
    bit          model_known [MEM_BYTES];   // written at least once
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;           // counts at the start of a test
    int          test_errors = 0;
    int          tests_run = 0;

    always #(CLK_PERIOD / 2) wclk = ~wclk;

    cart_mem_bridge #(
        .ADDR_W (ADDR_W)
    ) dut_i (
        .wclk        (wclk),
        .resetn      (resetn),
        .apb_req     (apb_req),
        .rom_req     (rom_req),
        .wram_req    (wram_req),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .apb_rsp     (apb_rsp),
        .snes_enable (snes_enable),
        .rom_q       (rom_q),
        .wram_q      (wram_q)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // higher address bits alias onto the ram
    function automatic int model_index(input logic [22:0] cart_addr);
        return int'(cart_addr[ADDR_W-1:0]);
    endfunction

    function automatic logic [15:0] rom_expect(input logic [22:0] addr, input logic word);
        int          even;
        logic [15:0] w;
        even = model_index(addr) & ~1;
        w    = {model_mem[even + 1], model_mem[even]};
        return (!word && addr[0]) ? {w[7:0], w[15:8]} : w;   // odd byte access swaps
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
        tests_run++;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic idle_snes();
        rom_req    = '0;
        wram_req   = '0;
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
    endtask

    // result settles two edges after the sampling edge
    task automatic wait_pipeline();
        @(negedge wclk);
        idle_snes();
        repeat (2) @(negedge wclk);
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        @(negedge wclk);
        apb_req.psel    = 1'b1;                 // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge wclk);
        apb_req.penable = 1'b1;                 // access phase
        #(CLK_PERIOD / 4);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_eq("pready", 32'(apb_rsp.pready), 1);   // no wait states
        @(negedge wclk);
        apb_req = '0;
    endtask

    task automatic wram_write(input logic [16:0] addr, input logic [7:0] data);
        @(negedge wclk);
        wram_req.wr   = 1'b1;
        wram_req.addr = addr;
        wram_req.data = data;
        sysclkr_ce    = 1'b1;
        @(negedge wclk);
        idle_snes();
        model_mem[model_index(WRAM_TOP + 23'(addr))]   = data;
        model_known[model_index(WRAM_TOP + 23'(addr))] = 1'b1;
    endtask

    task automatic wram_read(input logic [16:0] addr);
        @(negedge wclk);
        wram_req.rd   = 1'b1;
        wram_req.addr = addr;
        sysclkf_ce    = 1'b1;
        wait_pipeline();
        check_eq("wram_q", 32'(wram_q), 32'(model_mem[model_index(WRAM_TOP + 23'(addr))]));
    endtask

    task automatic rom_read(input logic [22:0] addr, input logic word);
        @(negedge wclk);
        rom_req.ce   = 1'b1;
        rom_req.word = word;
        rom_req.addr = addr;
        sysclkf_ce   = 1'b1;
        wait_pipeline();
        check_eq("rom_q", 32'(rom_q), 32'(rom_expect(addr, word)));
    endtask

    // run limit
    always @(posedge wclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        logic        slverr;
        logic [16:0] waddr;
        logic [22:0] raddr;
        logic [15:0] rom_hold;
        logic [7:0]  wram_hold;
        logic [7:0]  b;
        logic        do_write;
        int          wait_cycles;

        resetn  = 1'b0;
        apb_req = '0;
        idle_snes();
        repeat (4) @(posedge wclk);
        @(negedge wclk);
        resetn = 1'b1;

        check_eq("snes_enable after reset", 32'(snes_enable), 0);
        check_eq("rom_q after reset", 32'(rom_q), 0);
        check_eq("wram_q after reset", 32'(wram_q), 0);
        apb_access(1'b0, REG_STATUS, 0, rdata, slverr);
        check_eq("status after reset", rdata, 0);
        finish_test("reset");

        apb_access(1'b1, REG_CTRL, 32'h1, rdata, slverr);      // start loading
        for (int i = 0; i < 256; i++) begin
            b = 8'(rand_bits(8));
            apb_access(1'b1, REG_DATA, {24'h0, b}, rdata, slverr);
            check_eq("pslverr on load write", 32'(slverr), 0);
            model_mem[model_index(23'(i))] = b;
        end
        check_eq("snes_enable while loading", 32'(snes_enable), 0);
        apb_access(1'b1, REG_CTRL, 32'h0, rdata, slverr);      // end loading
        wait_cycles = 0;
        while (snes_enable !== 1'b1 && wait_cycles < 4) begin
            @(negedge wclk);
            wait_cycles++;
        end
        check_eq("snes_enable after loading", 32'(snes_enable), 1);
        apb_access(1'b0, REG_STATUS, 0, rdata, slverr);
        check_eq("status after loading", rdata, 32'h0001_0002);  // loader addr 256 and loaded
        finish_test("loading");

        for (int i = 0; i < 200; i++) begin
            raddr = 23'(rand_bits(8));
            rom_read(raddr, 1'(rand_bits(1)));
        end
        finish_test("rom reads");

        for (int i = 0; i < 200; i++) begin
            waddr    = {3'(rand_bits(3)), 8'h80, 6'(rand_bits(6))};   // 64 byte window
            do_write = 1'(rand_bits(1));
            if (do_write || !model_known[model_index(WRAM_TOP + 23'(waddr))]) begin
                wram_write(waddr, 8'(rand_bits(8)));
            end else begin
                wram_read(waddr);
            end
        end
        finish_test("wram");

        wram_write(17'h00100, 8'(rand_bits(8)));   // known bytes where the loader points
        wram_write(17'h00101, 8'(rand_bits(8)));
        apb_access(1'b1, REG_DATA, {24'h0, ~model_mem[256]}, rdata, slverr);
        check_eq("pslverr on idle data write", 32'(slverr), 1);
        rom_read(23'h000100, 1'b1);
        apb_access(1'b0, 12'h00c, 0, rdata, slverr);
        check_eq("pslverr on unmapped offset", 32'(slverr), 1);

        wram_hold = wram_q;
        wram_write(17'h02040, ~wram_hold);
        raddr = 23'(rand_bits(8));
        @(negedge wclk);
        rom_req.ce    = 1'b1;                      // rom wins over the wram read
        rom_req.addr  = raddr;
        wram_req.rd   = 1'b1;
        wram_req.addr = 17'h02040;
        sysclkf_ce    = 1'b1;
        wait_pipeline();
        check_eq("rom_q with wram read", 32'(rom_q), 32'(rom_expect(raddr, 1'b0)));
        check_eq("wram_q after losing", 32'(wram_q), 32'(wram_hold));

        rom_hold  = rom_q;
        wram_hold = wram_q;
        @(negedge wclk);
        rom_req.ce    = 1'b1;                      // no enables at all
        rom_req.addr  = raddr ^ 23'h1;
        wram_req.rd   = 1'b1;
        wram_req.wr   = 1'b1;
        wram_req.addr = 17'h02040;
        wram_req.data = ~model_mem[model_index(WRAM_TOP + 23'h02040)];
        wait_pipeline();
        check_eq("rom_q without enable", 32'(rom_q), 32'(rom_hold));
        check_eq("wram_q without enable", 32'(wram_q), 32'(wram_hold));
        wram_read(17'h02040);                      // stray write would show here
        finish_test("errors and priority");

        errors += dut_i.assertions_i.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cart_mem_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cart_mem_bridge_assertions (
    input logic                   wclk,
    input logic                   resetn,
    input cart_mem_pkg::apb_req_t apb_req,
    input cart_mem_pkg::apb_rsp_t apb_rsp,
    input cart_mem_pkg::load_wr_t load_wr,
    input cart_mem_pkg::mem_cmd_t mem_cmd,
    input logic                   loading,
    input logic                   snes_enable
);
    int fail_count = 0;     // failed properties so far

    cmd_one_dir: assert property (@(posedge wclk) disable iff (!resetn)
        !(mem_cmd.rd && mem_cmd.wr))
        else begin
            $error("memory command is read and write at once");
            fail_count++;
        end

    // snes held off while the rom is loaded
    enable_off_loading: assert property (@(posedge wclk) disable iff (!resetn)
        loading |-> !snes_enable)
        else begin
            $error("snes_enable high while loading");
            fail_count++;
        end

    slverr_access_only: assert property (@(posedge wclk) disable iff (!resetn)
        apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
        else begin
            $error("pslverr outside the access phase");
            fail_count++;
        end

    load_pulse_loading: assert property (@(posedge wclk) disable iff (!resetn)
        load_wr.valid |-> loading)
        else begin
            $error("loader write pulse while not loading");
            fail_count++;
        end

endmodule

bind cart_mem_bridge cart_mem_bridge_assertions assertions_i (
    .wclk        (wclk),
    .resetn      (resetn),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .load_wr     (load_wr),
    .mem_cmd     (mem_cmd),
    .loading     (loading),
    .snes_enable (snes_enable)
);

`default_nettype wire

//--- cart_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module cart_mem_bridge #(
    parameter int ADDR_W = cart_mem_pkg::ADDR_W_DEFAULT   // on-chip ram size, log2 bytes
) (
    input  logic                    wclk,
    input  logic                    resetn,
    input  cart_mem_pkg::apb_req_t  apb_req,      // rom loading host
    input  cart_mem_pkg::rom_req_t  rom_req,      // snes rom port
    input  cart_mem_pkg::wram_req_t wram_req,     // snes wram port
    input  logic                    sysclkf_ce,
    input  logic                    sysclkr_ce,
    output cart_mem_pkg::apb_rsp_t  apb_rsp,
    output logic                    snes_enable,
    output logic [15:0]             rom_q,
    output logic [7:0]              wram_q
);
    import cart_mem_pkg::*;

    load_wr_t load_wr;      // loader byte pulse
    logic     loading;
    mem_cmd_t mem_cmd;      // stage 1 -> 2
    rd_rsp_t  rd_rsp;       // stage 2 -> 3

    loader_apb_regs loader_i (
        .wclk        (wclk),
        .resetn      (resetn),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .load_wr     (load_wr),
        .loading     (loading),
        .snes_enable (snes_enable)
    );

    // stage 1, pick one request per cycle
    mem_req_arbiter arbiter_i (
        .wclk       (wclk),
        .resetn     (resetn),
        .load_wr    (load_wr),
        .loading    (loading),
        .rom_req    (rom_req),
        .wram_req   (wram_req),
        .sysclkf_ce (sysclkf_ce),
        .sysclkr_ce (sysclkr_ce),
        .mem_cmd    (mem_cmd)
    );

    // stage 2, stands in for the sdram
    byte_lane_ram #(
        .ADDR_W (ADDR_W)
    ) ram_i (
        .wclk    (wclk),
        .resetn  (resetn),
        .mem_cmd (mem_cmd),
        .rd_rsp  (rd_rsp)
    );

    // stage 3, byte steering and hold
    read_data_steer steer_i (
        .wclk   (wclk),
        .resetn (resetn),
        .rd_rsp (rd_rsp),
        .rom_q  (rom_q),
        .wram_q (wram_q)
    );

endmodule

`default_nettype wire

//--- read_data_steer.sv
`timescale 1ns/1ps
`default_nettype none

module read_data_steer (
    input  logic                  wclk,
    input  logic                  resetn,
    input  cart_mem_pkg::rd_rsp_t rd_rsp,
    output logic [15:0]           rom_q,      // held rom word
    output logic [7:0]            wram_q      // held wram byte
);
    import cart_mem_pkg::*;

    logic [15:0] rom_word;
    logic [7:0]  wram_byte;
    logic        swap;

    // odd byte access: wanted byte sits in the high lane, move it down
    assign swap     = ~rd_rsp.word & rd_rsp.lsb;
    assign rom_word = swap ? {rd_rsp.data[7:0], rd_rsp.data[15:8]} : rd_rsp.data;

    // wram is byte wide, pick the lane by address bit 0
    assign wram_byte = rd_rsp.lsb ? rd_rsp.data[15:8] : rd_rsp.data[7:0];

    // each output only moves on its own response
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rom_q  <= '0;
            wram_q <= '0;
        end else if (rd_rsp.valid) begin
            if (rd_rsp.port == port_rom) begin
                rom_q <= rom_word;
            end else begin
                wram_q <= wram_byte;
            end
        end
    end

endmodule

`default_nettype wire

//--- byte_lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram #(
    parameter int ADDR_W = cart_mem_pkg::ADDR_W_DEFAULT   // bytes = 2**ADDR_W
) (
    input  logic                   wclk,
    input  logic                   resetn,
    input  cart_mem_pkg::mem_cmd_t mem_cmd,
    output cart_mem_pkg::rd_rsp_t  rd_rsp
);
    import cart_mem_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_W - 1);     // 16-bit words

    logic [15:0]       mem [DEPTH];
    logic [ADDR_W-2:0] idx;                       // word index, upper bits alias
    logic              rsp_valid;
    mem_port_e         rsp_port;
    logic              rsp_word;
    logic              rsp_lsb;
    logic [15:0]       rsp_data;

    assign idx = mem_cmd.addr[ADDR_W-1:1];

    // array and read payload
    always_ff @(posedge wclk) begin
        if (mem_cmd.wr) begin
            if (mem_cmd.ds[0]) mem[idx][7:0]  <= mem_cmd.din[7:0];    // even byte
            if (mem_cmd.ds[1]) mem[idx][15:8] <= mem_cmd.din[15:8];   // odd byte
        end
        if (mem_cmd.rd) begin
            rsp_data <= mem[idx];
            rsp_port <= mem_cmd.port;
            rsp_word <= mem_cmd.word;
            rsp_lsb  <= mem_cmd.addr[0];
        end
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= mem_cmd.rd;
        end
    end

    always_comb begin
        rd_rsp.valid = rsp_valid;
        rd_rsp.port  = rsp_port;
        rd_rsp.word  = rsp_word;
        rd_rsp.lsb   = rsp_lsb;
        rd_rsp.data  = rsp_data;
    end

endmodule

`default_nettype wire

//--- mem_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_req_arbiter (
    input  logic                    wclk,
    input  logic                    resetn,
    input  cart_mem_pkg::load_wr_t  load_wr,
    input  logic                    loading,
    input  cart_mem_pkg::rom_req_t  rom_req,
    input  cart_mem_pkg::wram_req_t wram_req,
    input  logic                    sysclkf_ce,     // fall enable, reads
    input  logic                    sysclkr_ce,     // rise enable, wram writes
    output cart_mem_pkg::mem_cmd_t  mem_cmd
);
    import cart_mem_pkg::*;

    mem_cmd_t cmd_next;
    logic     load_go;
    logic     rom_rd;
    logic     wram_rd;
    logic     wram_wr;

    // qualified requests
    assign load_go = loading & load_wr.valid;
    assign rom_rd  = rom_req.ce & sysclkf_ce;
    assign wram_rd = wram_req.rd & sysclkf_ce;
    assign wram_wr = wram_req.wr & sysclkr_ce;

    // fixed priority: loader, rom, wram
    always_comb begin
        cmd_next = '0;                              // idle unless a request wins
        if (loading) begin
            // snes side is held off while loading
            if (load_go) begin
                cmd_next.wr   = 1'b1;
                cmd_next.port = port_rom;
                cmd_next.addr = load_wr.addr;
                cmd_next.ds   = {load_wr.addr[0], ~load_wr.addr[0]};
                cmd_next.din  = {load_wr.data, load_wr.data};   // byte on both lanes
            end
        end else if (rom_rd) begin
            cmd_next.rd   = 1'b1;
            cmd_next.port = port_rom;
            cmd_next.word = rom_req.word;           // steering needs it later
            cmd_next.addr = rom_req.addr;
            cmd_next.ds   = 2'b11;                  // always fetch the full word
        end else if (wram_rd || wram_wr) begin
            cmd_next.rd   = wram_rd;
            cmd_next.wr   = ~wram_rd;               // read wins, never both
            cmd_next.port = port_wram;
            cmd_next.addr = WRAM_BASE + CART_AW'(wram_req.addr);
            cmd_next.ds   = {wram_req.addr[0], ~wram_req.addr[0]};
            cmd_next.din  = {wram_req.data, wram_req.data};
        end
    end

    // one registered command per cycle, a lost request is simply gone
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            mem_cmd <= '0;
        end else begin
            mem_cmd <= cmd_next;
        end
    end

endmodule

`default_nettype wire

//--- loader_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module loader_apb_regs (
    input  logic                   wclk,
    input  logic                   resetn,
    input  cart_mem_pkg::apb_req_t apb_req,       // host bus
    output cart_mem_pkg::apb_rsp_t apb_rsp,
    output cart_mem_pkg::load_wr_t load_wr,       // byte writes toward memory
    output logic                   loading,
    output logic                   snes_enable    // snes may run
);
    import cart_mem_pkg::*;

    logic               access;         // apb access phase
    logic               wr_access;
    logic               sel_ctrl;
    logic               sel_data;
    logic               sel_status;
    logic               unmapped;
    logic               start_load;     // ctrl <= 1
    logic               end_load;       // ctrl <= 0 while loading
    logic               data_wr;        // accepted data byte
    logic               data_err;       // data write while idle
    logic               loaded;
    logic [CART_AW-1:0] loader_addr;    // next byte lands here
    logic               wr_valid;
    logic [CART_AW-1:0] wr_addr;
    logic [7:0]         wr_data;

    // decode
    assign access     = apb_req.psel & apb_req.penable;
    assign wr_access  = access & apb_req.pwrite;
    assign sel_ctrl   = apb_req.paddr == REG_CTRL;
    assign sel_data   = apb_req.paddr == REG_DATA;
    assign sel_status = apb_req.paddr == REG_STATUS;
    assign unmapped   = ~(sel_ctrl | sel_data | sel_status);

    assign start_load = wr_access & sel_ctrl & apb_req.pwdata[0];
    assign end_load   = wr_access & sel_ctrl & ~apb_req.pwdata[0] & loading;
    assign data_wr    = wr_access & sel_data & loading;
    assign data_err   = wr_access & sel_data & ~loading;   // dropped, flagged

    // no wait states, read data only in the access phase
    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & (unmapped | data_err);
        if (access && !apb_req.pwrite) begin
            if (sel_ctrl) begin
                apb_rsp.prdata[0] = loading;
            end else if (sel_status) begin
                apb_rsp.prdata[0]            = loading;
                apb_rsp.prdata[1]            = loaded;
                apb_rsp.prdata[8 +: CART_AW] = loader_addr;
            end
        end
    end

    // loading state and loader address
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading     <= 1'b0;
            loaded      <= 1'b0;
            loader_addr <= '0;
            snes_enable <= 1'b0;
        end else begin
            if (start_load) begin            // (re)start from byte 0
                loading     <= 1'b1;
                loaded      <= 1'b0;
                loader_addr <= '0;
            end else if (end_load) begin
                loading <= 1'b0;
                loaded  <= 1'b1;
            end else if (data_wr) begin
                loader_addr <= loader_addr + 1'b1;   // advance after issue
            end
            // drops on the start edge, rises one edge after the end
            snes_enable <= loaded & ~loading & ~start_load;
        end
    end

    // byte write pulse
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= data_wr;
        end
    end

    always_ff @(posedge wclk) begin
        if (data_wr) begin
            wr_addr <= loader_addr;
            wr_data <= apb_req.pwdata[7:0];     // low byte only
        end
    end

    always_comb begin
        load_wr.valid = wr_valid;
        load_wr.addr  = wr_addr;
        load_wr.data  = wr_data;
    end

endmodule

`default_nettype wire

//--- cart_mem_pkg.sv
`default_nettype none

package cart_mem_pkg;

    // cartridge address space
    localparam int CART_AW        = 23;      // byte address, 8MB cart space
    localparam int WRAM_AW        = 17;      // 128KB work ram
    localparam int ADDR_W_DEFAULT = 14;      // 16KB on-chip ram

    // wram lives at the top of the cart space, upper bits all ones
    localparam logic [CART_AW-1:0] WRAM_BASE = {{(CART_AW-WRAM_AW){1'b1}}, {WRAM_AW{1'b0}}};

    // apb register map, byte offsets
    localparam logic [11:0] REG_CTRL   = 12'h000;   // bit 0: loading
    localparam logic [11:0] REG_DATA   = 12'h004;   // write one rom byte
    localparam logic [11:0] REG_STATUS = 12'h008;   // loading, loaded, loader addr

    // which snes port a memory access belongs to
    typedef enum logic {
        port_rom  = 1'b0,
        port_wram = 1'b1
    } mem_port_e;

    // apb host side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // one loader byte, valid is a single-cycle pulse
    typedef struct packed {
        logic               valid;
        logic [CART_AW-1:0] addr;
        logic [7:0]         data;
    } load_wr_t;

    // snes rom port, ce active high here
    typedef struct packed {
        logic               ce;
        logic               word;     // 16-bit fetch
        logic [CART_AW-1:0] addr;
    } rom_req_t;

    // snes wram port
    typedef struct packed {
        logic               rd;
        logic               wr;
        logic [WRAM_AW-1:0] addr;
        logic [7:0]         data;
    } wram_req_t;

    // one memory command per cycle out of the arbiter
    typedef struct packed {
        logic               rd;
        logic               wr;
        mem_port_e          port;
        logic               word;     // companion of rom_req.word, 0 for wram
        logic [CART_AW-1:0] addr;     // byte address
        logic [1:0]         ds;       // lane mask, bit 0 = even byte
        logic [15:0]        din;
    } mem_cmd_t;

    // tagged read response from the ram
    typedef struct packed {
        logic        valid;
        mem_port_e   port;
        logic        word;
        logic        lsb;             // byte address bit 0 of the request
        logic [15:0] data;
    } rd_rsp_t;

endpackage

`default_nettype wire
